// File: l2_pkg.sv
package l2_pkg;

  // Widths of the request front-end
  localparam int SRC_ID_W  = 2;
  localparam int PADDR_W   = 32;
  localparam int REQ_TAG_W = 4;
  localparam int L2_TAG_W  = SRC_ID_W + REQ_TAG_W;

  typedef enum logic [1:0] {
    CMD_RD = 2'd0,
    CMD_WR = 2'd1
  } mem_cmd_t;

  // Code 3 is not assigned to any requester
  typedef enum logic [SRC_ID_W-1:0] {
    SRC_IC  = 2'd0,
    SRC_L1D = 2'd1,
    SRC_PTW = 2'd2
  } src_id_t;

  // -------------------------------------------------------------------
  // Tag helpers, source id sits in the top bits
  // -------------------------------------------------------------------
  function automatic logic [L2_TAG_W-1:0] l2_tag_make(
      input src_id_t src,
      input logic [REQ_TAG_W-1:0] tag
  );
    l2_tag_make = {src, tag};
  endfunction

  function automatic src_id_t l2_tag_src(input logic [L2_TAG_W-1:0] tag);
    l2_tag_src = src_id_t'(tag[L2_TAG_W-1 -: SRC_ID_W]);
  endfunction

  function automatic logic [REQ_TAG_W-1:0] l2_tag_req(input logic [L2_TAG_W-1:0] tag);
    l2_tag_req = tag[REQ_TAG_W-1:0];
  endfunction

endpackage

// File: l2_req_arbiter.sv
module l2_req_arbiter
  import l2_pkg::*;
#(
    parameter int DATA_W = 64,
    localparam int BE_W = DATA_W / 8
) (
    input  logic                 i_clk,
    input  logic                 i_rst_n,

    input  logic                 i_ic_req_valid,
    input  mem_cmd_t             i_ic_req_cmd,
    input  logic [PADDR_W-1:0]   i_ic_req_addr,
    input  logic [REQ_TAG_W-1:0] i_ic_req_tag,
    input  logic [DATA_W-1:0]    i_ic_req_data,
    input  logic [BE_W-1:0]      i_ic_req_byte_en,
    output logic                 o_ic_req_ready,

    input  logic                 i_l1d_req_valid,
    input  mem_cmd_t             i_l1d_req_cmd,
    input  logic [PADDR_W-1:0]   i_l1d_req_addr,
    input  logic [REQ_TAG_W-1:0] i_l1d_req_tag,
    input  logic [DATA_W-1:0]    i_l1d_req_data,
    input  logic [BE_W-1:0]      i_l1d_req_byte_en,
    output logic                 o_l1d_req_ready,

    input  logic                 i_ptw_req_valid,
    input  mem_cmd_t             i_ptw_req_cmd,
    input  logic [PADDR_W-1:0]   i_ptw_req_addr,
    input  logic [REQ_TAG_W-1:0] i_ptw_req_tag,
    input  logic [DATA_W-1:0]    i_ptw_req_data,
    input  logic [BE_W-1:0]      i_ptw_req_byte_en,
    output logic                 o_ptw_req_ready,

    output logic                 o_arb_valid,
    output mem_cmd_t             o_arb_cmd,
    output logic [PADDR_W-1:0]   o_arb_addr,
    output logic [L2_TAG_W-1:0]  o_arb_tag,
    output logic [DATA_W-1:0]    o_arb_data,
    output logic [BE_W-1:0]      o_arb_byte_en,
    input  logic                 i_arb_ready
);

  logic [2:0] req_vld;
  src_id_t    rr_ptr;
  src_id_t    cand;
  src_id_t    grant_src;
  logic       grant_vld;
  logic       load;

  function automatic src_id_t next_src(input src_id_t s);
    case (s)
      SRC_IC:  next_src = SRC_L1D;
      SRC_L1D: next_src = SRC_PTW;
      default: next_src = SRC_IC;
    endcase
  endfunction

  assign req_vld = {i_ptw_req_valid, i_l1d_req_valid, i_ic_req_valid};

  // First valid source at or after the pointer
  always_comb begin
    cand      = rr_ptr;
    grant_vld = 1'b0;
    grant_src = rr_ptr;
    for (int i = 0; i < 3; i++) begin
      if (!grant_vld && req_vld[cand]) begin
        grant_vld = 1'b1;
        grant_src = cand;
      end
      cand = next_src(cand);
    end
  end

  // Register empty or draining this cycle
  assign load = grant_vld && (!o_arb_valid || i_arb_ready);

  assign o_ic_req_ready  = load && (grant_src == SRC_IC);
  assign o_l1d_req_ready = load && (grant_src == SRC_L1D);
  assign o_ptw_req_ready = load && (grant_src == SRC_PTW);

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_arb_valid <= 1'b0;
      rr_ptr      <= SRC_IC;
    end else begin
      if (load) begin
        o_arb_valid <= 1'b1;
        rr_ptr      <= next_src(grant_src);
      end else if (i_arb_ready) begin
        o_arb_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (load) begin
      case (grant_src)
        SRC_IC: begin
          o_arb_cmd     <= i_ic_req_cmd;
          o_arb_addr    <= i_ic_req_addr;
          o_arb_tag     <= l2_tag_make(SRC_IC, i_ic_req_tag);
          o_arb_data    <= i_ic_req_data;
          o_arb_byte_en <= i_ic_req_byte_en;
        end
        SRC_L1D: begin
          o_arb_cmd     <= i_l1d_req_cmd;
          o_arb_addr    <= i_l1d_req_addr;
          o_arb_tag     <= l2_tag_make(SRC_L1D, i_l1d_req_tag);
          o_arb_data    <= i_l1d_req_data;
          o_arb_byte_en <= i_l1d_req_byte_en;
        end
        default: begin
          o_arb_cmd     <= i_ptw_req_cmd;
          o_arb_addr    <= i_ptw_req_addr;
          o_arb_tag     <= l2_tag_make(SRC_PTW, i_ptw_req_tag);
          o_arb_data    <= i_ptw_req_data;
          o_arb_byte_en <= i_ptw_req_byte_en;
        end
      endcase
    end
  end

  a_one_ready : assert property (@(posedge i_clk) disable iff (!i_rst_n)
    $onehot0({o_ic_req_ready, o_l1d_req_ready, o_ptw_req_ready}));

  a_rst_idle : assert property (@(posedge i_clk) !i_rst_n |-> !o_arb_valid);

endmodule

// File: l2_req_slice.sv
module l2_req_slice
  import l2_pkg::*;
#(
    parameter int DATA_W = 64,
    localparam int BE_W = DATA_W / 8
) (
    input  logic                i_clk,
    input  logic                i_rst_n,

    input  logic                i_arb_valid,
    input  mem_cmd_t            i_arb_cmd,
    input  logic [PADDR_W-1:0]  i_arb_addr,
    input  logic [L2_TAG_W-1:0] i_arb_tag,
    input  logic [DATA_W-1:0]   i_arb_data,
    input  logic [BE_W-1:0]     i_arb_byte_en,
    output logic                o_arb_ready,

    output logic                o_l2_req_valid,
    output mem_cmd_t            o_l2_req_cmd,
    output logic [PADDR_W-1:0]  o_l2_req_addr,
    output logic [L2_TAG_W-1:0] o_l2_req_tag,
    output logic [DATA_W-1:0]   o_l2_req_data,
    output logic [BE_W-1:0]     o_l2_req_byte_en,
    input  logic                i_l2_req_ready
);

  // Skid entry holds the one item caught by a stall
  logic                skid_vld;
  mem_cmd_t            skid_cmd;
  logic [PADDR_W-1:0]  skid_addr;
  logic [L2_TAG_W-1:0] skid_tag;
  logic [DATA_W-1:0]   skid_data;
  logic [BE_W-1:0]     skid_byte_en;

  logic in_fire;
  logic out_open;

  // Ready comes from a flop only
  assign o_arb_ready = !skid_vld;
  assign in_fire     = i_arb_valid && o_arb_ready;
  assign out_open    = !o_l2_req_valid || i_l2_req_ready;

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_l2_req_valid <= 1'b0;
      skid_vld       <= 1'b0;
    end else if (out_open) begin
      o_l2_req_valid <= skid_vld || in_fire;
      skid_vld       <= 1'b0;
    end else if (in_fire) begin
      skid_vld <= 1'b1;
    end
  end

  always_ff @(posedge i_clk) begin
    if (out_open && skid_vld) begin
      o_l2_req_cmd     <= skid_cmd;
      o_l2_req_addr    <= skid_addr;
      o_l2_req_tag     <= skid_tag;
      o_l2_req_data    <= skid_data;
      o_l2_req_byte_en <= skid_byte_en;
    end else if (out_open && in_fire) begin
      o_l2_req_cmd     <= i_arb_cmd;
      o_l2_req_addr    <= i_arb_addr;
      o_l2_req_tag     <= i_arb_tag;
      o_l2_req_data    <= i_arb_data;
      o_l2_req_byte_en <= i_arb_byte_en;
    end
    if (!out_open && in_fire) begin
      skid_cmd     <= i_arb_cmd;
      skid_addr    <= i_arb_addr;
      skid_tag     <= i_arb_tag;
      skid_data    <= i_arb_data;
      skid_byte_en <= i_arb_byte_en;
    end
  end

  a_hold : assert property (@(posedge i_clk) disable iff (!i_rst_n)
    o_l2_req_valid && !i_l2_req_ready |=> o_l2_req_valid &&
      $stable({o_l2_req_cmd, o_l2_req_addr, o_l2_req_tag, o_l2_req_data, o_l2_req_byte_en}));

endmodule

// File: l2_resp_router.sv
module l2_resp_router
  import l2_pkg::*;
#(
    parameter int DATA_W = 64
) (
    input  logic                 i_clk,
    input  logic                 i_rst_n,

    input  logic                 i_l2_resp_valid,
    input  logic [L2_TAG_W-1:0]  i_l2_resp_tag,
    input  logic [DATA_W-1:0]    i_l2_resp_data,
    output logic                 o_l2_resp_ready,

    output logic                 o_ic_resp_valid,
    output logic [REQ_TAG_W-1:0] o_ic_resp_tag,
    output logic [DATA_W-1:0]    o_ic_resp_data,
    input  logic                 i_ic_resp_ready,

    output logic                 o_l1d_resp_valid,
    output logic [REQ_TAG_W-1:0] o_l1d_resp_tag,
    output logic [DATA_W-1:0]    o_l1d_resp_data,
    input  logic                 i_l1d_resp_ready,

    output logic                 o_ptw_resp_valid,
    output logic [REQ_TAG_W-1:0] o_ptw_resp_tag,
    output logic [DATA_W-1:0]    o_ptw_resp_data,
    input  logic                 i_ptw_resp_ready
);

  logic                ent_vld;
  logic [L2_TAG_W-1:0] ent_tag;
  logic [DATA_W-1:0]   ent_data;
  src_id_t             ent_src;
  logic                dst_ready;
  logic                ent_take;
  logic                resp_fire;

  assign ent_src = l2_tag_src(ent_tag);

  always_comb begin
    case (ent_src)
      SRC_IC:  dst_ready = i_ic_resp_ready;
      SRC_L1D: dst_ready = i_l1d_resp_ready;
      SRC_PTW: dst_ready = i_ptw_resp_ready;
      default: dst_ready = 1'b0;
    endcase
  end

  assign ent_take        = ent_vld && dst_ready;
  assign o_l2_resp_ready = !ent_vld || ent_take;
  assign resp_fire       = i_l2_resp_valid && o_l2_resp_ready;

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      ent_vld <= 1'b0;
    end else begin
      ent_vld <= resp_fire || (ent_vld && !ent_take);
    end
  end

  always_ff @(posedge i_clk) begin
    if (resp_fire) begin
      ent_tag  <= i_l2_resp_tag;
      ent_data <= i_l2_resp_data;
    end
  end

  // Only the named requester sees valid
  assign o_ic_resp_valid  = ent_vld && (ent_src == SRC_IC);
  assign o_l1d_resp_valid = ent_vld && (ent_src == SRC_L1D);
  assign o_ptw_resp_valid = ent_vld && (ent_src == SRC_PTW);

  assign o_ic_resp_tag  = l2_tag_req(ent_tag);
  assign o_l1d_resp_tag = l2_tag_req(ent_tag);
  assign o_ptw_resp_tag = l2_tag_req(ent_tag);

  assign o_ic_resp_data  = ent_data;
  assign o_l1d_resp_data = ent_data;
  assign o_ptw_resp_data = ent_data;

  a_src_known : assert property (@(posedge i_clk) disable iff (!i_rst_n)
    resp_fire |-> l2_tag_src(i_l2_resp_tag) inside {SRC_IC, SRC_L1D, SRC_PTW});

endmodule

// File: tile_l2_wrapper.sv
module tile_l2_wrapper
  import l2_pkg::*;
#(
    parameter int DATA_W = 64,
    localparam int BE_W = DATA_W / 8
) (
    input  logic                 i_clk,
    input  logic                 i_rst_n,

    // ICache
    input  logic                 i_ic_req_valid,
    input  mem_cmd_t             i_ic_req_cmd,
    input  logic [PADDR_W-1:0]   i_ic_req_addr,
    input  logic [REQ_TAG_W-1:0] i_ic_req_tag,
    input  logic [DATA_W-1:0]    i_ic_req_data,
    input  logic [BE_W-1:0]      i_ic_req_byte_en,
    output logic                 o_ic_req_ready,
    output logic                 o_ic_resp_valid,
    output logic [REQ_TAG_W-1:0] o_ic_resp_tag,
    output logic [DATA_W-1:0]    o_ic_resp_data,
    input  logic                 i_ic_resp_ready,

    // L1D
    input  logic                 i_l1d_req_valid,
    input  mem_cmd_t             i_l1d_req_cmd,
    input  logic [PADDR_W-1:0]   i_l1d_req_addr,
    input  logic [REQ_TAG_W-1:0] i_l1d_req_tag,
    input  logic [DATA_W-1:0]    i_l1d_req_data,
    input  logic [BE_W-1:0]      i_l1d_req_byte_en,
    output logic                 o_l1d_req_ready,
    output logic                 o_l1d_resp_valid,
    output logic [REQ_TAG_W-1:0] o_l1d_resp_tag,
    output logic [DATA_W-1:0]    o_l1d_resp_data,
    input  logic                 i_l1d_resp_ready,

    // Page table walker
    input  logic                 i_ptw_req_valid,
    input  mem_cmd_t             i_ptw_req_cmd,
    input  logic [PADDR_W-1:0]   i_ptw_req_addr,
    input  logic [REQ_TAG_W-1:0] i_ptw_req_tag,
    input  logic [DATA_W-1:0]    i_ptw_req_data,
    input  logic [BE_W-1:0]      i_ptw_req_byte_en,
    output logic                 o_ptw_req_ready,
    output logic                 o_ptw_resp_valid,
    output logic [REQ_TAG_W-1:0] o_ptw_resp_tag,
    output logic [DATA_W-1:0]    o_ptw_resp_data,
    input  logic                 i_ptw_resp_ready,

    // L2 side
    output logic                 o_l2_req_valid,
    output mem_cmd_t             o_l2_req_cmd,
    output logic [PADDR_W-1:0]   o_l2_req_addr,
    output logic [L2_TAG_W-1:0]  o_l2_req_tag,
    output logic [DATA_W-1:0]    o_l2_req_data,
    output logic [BE_W-1:0]      o_l2_req_byte_en,
    input  logic                 i_l2_req_ready,
    input  logic                 i_l2_resp_valid,
    input  logic [L2_TAG_W-1:0]  i_l2_resp_tag,
    input  logic [DATA_W-1:0]    i_l2_resp_data,
    output logic                 o_l2_resp_ready
);

  logic                arb_valid;
  mem_cmd_t            arb_cmd;
  logic [PADDR_W-1:0]  arb_addr;
  logic [L2_TAG_W-1:0] arb_tag;
  logic [DATA_W-1:0]   arb_data;
  logic [BE_W-1:0]     arb_byte_en;
  logic                arb_ready;

  // ---------------------------------------------------------------------
  // Request side
  // ---------------------------------------------------------------------
  l2_req_arbiter #(
      .DATA_W(DATA_W)
  ) u_l2_req_arbiter (
      .i_clk            (i_clk),
      .i_rst_n          (i_rst_n),
      .i_ic_req_valid   (i_ic_req_valid),
      .i_ic_req_cmd     (i_ic_req_cmd),
      .i_ic_req_addr    (i_ic_req_addr),
      .i_ic_req_tag     (i_ic_req_tag),
      .i_ic_req_data    (i_ic_req_data),
      .i_ic_req_byte_en (i_ic_req_byte_en),
      .o_ic_req_ready   (o_ic_req_ready),
      .i_l1d_req_valid  (i_l1d_req_valid),
      .i_l1d_req_cmd    (i_l1d_req_cmd),
      .i_l1d_req_addr   (i_l1d_req_addr),
      .i_l1d_req_tag    (i_l1d_req_tag),
      .i_l1d_req_data   (i_l1d_req_data),
      .i_l1d_req_byte_en(i_l1d_req_byte_en),
      .o_l1d_req_ready  (o_l1d_req_ready),
      .i_ptw_req_valid  (i_ptw_req_valid),
      .i_ptw_req_cmd    (i_ptw_req_cmd),
      .i_ptw_req_addr   (i_ptw_req_addr),
      .i_ptw_req_tag    (i_ptw_req_tag),
      .i_ptw_req_data   (i_ptw_req_data),
      .i_ptw_req_byte_en(i_ptw_req_byte_en),
      .o_ptw_req_ready  (o_ptw_req_ready),
      .o_arb_valid      (arb_valid),
      .o_arb_cmd        (arb_cmd),
      .o_arb_addr       (arb_addr),
      .o_arb_tag        (arb_tag),
      .o_arb_data       (arb_data),
      .o_arb_byte_en    (arb_byte_en),
      .i_arb_ready      (arb_ready)
  );

  l2_req_slice #(
      .DATA_W(DATA_W)
  ) u_l2_req_slice (
      .i_clk           (i_clk),
      .i_rst_n         (i_rst_n),
      .i_arb_valid     (arb_valid),
      .i_arb_cmd       (arb_cmd),
      .i_arb_addr      (arb_addr),
      .i_arb_tag       (arb_tag),
      .i_arb_data      (arb_data),
      .i_arb_byte_en   (arb_byte_en),
      .o_arb_ready     (arb_ready),
      .o_l2_req_valid  (o_l2_req_valid),
      .o_l2_req_cmd    (o_l2_req_cmd),
      .o_l2_req_addr   (o_l2_req_addr),
      .o_l2_req_tag    (o_l2_req_tag),
      .o_l2_req_data   (o_l2_req_data),
      .o_l2_req_byte_en(o_l2_req_byte_en),
      .i_l2_req_ready  (i_l2_req_ready)
  );

  // ---------------------------------------------------------------------
  // Response side
  // ---------------------------------------------------------------------
  l2_resp_router #(
      .DATA_W(DATA_W)
  ) u_l2_resp_router (
      .i_clk           (i_clk),
      .i_rst_n         (i_rst_n),
      .i_l2_resp_valid (i_l2_resp_valid),
      .i_l2_resp_tag   (i_l2_resp_tag),
      .i_l2_resp_data  (i_l2_resp_data),
      .o_l2_resp_ready (o_l2_resp_ready),
      .o_ic_resp_valid (o_ic_resp_valid),
      .o_ic_resp_tag   (o_ic_resp_tag),
      .o_ic_resp_data  (o_ic_resp_data),
      .i_ic_resp_ready (i_ic_resp_ready),
      .o_l1d_resp_valid(o_l1d_resp_valid),
      .o_l1d_resp_tag  (o_l1d_resp_tag),
      .o_l1d_resp_data (o_l1d_resp_data),
      .i_l1d_resp_ready(i_l1d_resp_ready),
      .o_ptw_resp_valid(o_ptw_resp_valid),
      .o_ptw_resp_tag  (o_ptw_resp_tag),
      .o_ptw_resp_data (o_ptw_resp_data),
      .i_ptw_resp_ready(i_ptw_resp_ready)
  );

endmodule

// File: tb_clk_gen.sv
module tb_clk_gen #(
  parameter int PERIOD_NS  = 8,
  parameter int RST_CYCLES = 3
) (
  output logic o_clk,
  output logic o_rst_n
);
  timeunit 1ns;
  timeprecision 1ps;

  initial begin
    o_clk = 1'b0;
    forever #(PERIOD_NS / 2) o_clk = ~o_clk;
  end

  // Release on a falling edge, away from the sampling edge
  initial begin
    o_rst_n = 1'b0;
    repeat (RST_CYCLES) @(posedge o_clk);
    @(negedge o_clk);
    o_rst_n = 1'b1;
  end

endmodule

// File: tb_tile_l2.sv
module tb_tile_l2
  import l2_pkg::*;
();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int DATA_W  = 64;
  localparam int BE_W    = DATA_W / 8;
  localparam int N_FIELD = 7;
  localparam int N_PAT   = 21;
  localparam int N_RAND  = 12;
  localparam int TIMEOUT = 2000;
  localparam int F_SRC   = 0;
  localparam int F_CMD   = 1;
  localparam int F_ADDR  = 2;
  localparam int F_DATA  = 3;
  localparam int F_BE    = 4;
  localparam int F_TAG   = 5;
  localparam int F_RDATA = 6;

  logic                 clk;
  logic                 rst_n;
  logic                 req_valid [3];
  mem_cmd_t             req_cmd   [3];
  logic [PADDR_W-1:0]   req_addr  [3];
  logic [REQ_TAG_W-1:0] req_tag   [3];
  logic [DATA_W-1:0]    req_data  [3];
  logic [BE_W-1:0]      req_be    [3];
  logic                 req_ready [3];
  logic                 resp_valid [3];
  logic [REQ_TAG_W-1:0] resp_tag   [3];
  logic [DATA_W-1:0]    resp_data  [3];
  logic                 resp_ready [3];

  logic                 l2_req_valid;
  mem_cmd_t             l2_req_cmd;
  logic [PADDR_W-1:0]   l2_req_addr;
  logic [L2_TAG_W-1:0]  l2_req_tag;
  logic [DATA_W-1:0]    l2_req_data;
  logic [BE_W-1:0]      l2_req_be;
  logic                 l2_req_ready;
  logic                 l2_resp_valid;
  logic [L2_TAG_W-1:0]  l2_resp_tag;
  logic [DATA_W-1:0]    l2_resp_data;
  logic                 l2_resp_ready;

  logic [63:0]          pat_mem [N_PAT*N_FIELD];
  int                   drv_q [3][$];
  int                   exp_req_q [3][$];
  int                   exp_resp_q [3][$];
  logic [L2_TAG_W-1:0]  rtag_q [$];
  logic [DATA_W-1:0]    rdata_q [$];
  logic                 hold_prev [3];
  logic [REQ_TAG_W-1:0] hold_tag [3];
  logic [DATA_W-1:0]    hold_data [3];
  string                src_name [3];

  int         errors;
  int         checks;
  int         acc_count;
  int         l2_req_count;
  int         resp_count;
  int         burst_seen;
  logic [1:0] burst_prev;
  logic       in_burst;
  int         l2_mode;
  logic       timed_out;
  integer     seed = 4091;

  tb_clk_gen #(
    .PERIOD_NS (8),
    .RST_CYCLES(3)
  ) u_clk_gen (
    .o_clk  (clk),
    .o_rst_n(rst_n)
  );

  tile_l2_wrapper #(
    .DATA_W(DATA_W)
  ) u_dut (
    .i_clk            (clk),
    .i_rst_n          (rst_n),
    .i_ic_req_valid   (req_valid[0]),
    .i_ic_req_cmd     (req_cmd[0]),
    .i_ic_req_addr    (req_addr[0]),
    .i_ic_req_tag     (req_tag[0]),
    .i_ic_req_data    (req_data[0]),
    .i_ic_req_byte_en (req_be[0]),
    .o_ic_req_ready   (req_ready[0]),
    .o_ic_resp_valid  (resp_valid[0]),
    .o_ic_resp_tag    (resp_tag[0]),
    .o_ic_resp_data   (resp_data[0]),
    .i_ic_resp_ready  (resp_ready[0]),
    .i_l1d_req_valid  (req_valid[1]),
    .i_l1d_req_cmd    (req_cmd[1]),
    .i_l1d_req_addr   (req_addr[1]),
    .i_l1d_req_tag    (req_tag[1]),
    .i_l1d_req_data   (req_data[1]),
    .i_l1d_req_byte_en(req_be[1]),
    .o_l1d_req_ready  (req_ready[1]),
    .o_l1d_resp_valid (resp_valid[1]),
    .o_l1d_resp_tag   (resp_tag[1]),
    .o_l1d_resp_data  (resp_data[1]),
    .i_l1d_resp_ready (resp_ready[1]),
    .i_ptw_req_valid  (req_valid[2]),
    .i_ptw_req_cmd    (req_cmd[2]),
    .i_ptw_req_addr   (req_addr[2]),
    .i_ptw_req_tag    (req_tag[2]),
    .i_ptw_req_data   (req_data[2]),
    .i_ptw_req_byte_en(req_be[2]),
    .o_ptw_req_ready  (req_ready[2]),
    .o_ptw_resp_valid (resp_valid[2]),
    .o_ptw_resp_tag   (resp_tag[2]),
    .o_ptw_resp_data  (resp_data[2]),
    .i_ptw_resp_ready (resp_ready[2]),
    .o_l2_req_valid   (l2_req_valid),
    .o_l2_req_cmd     (l2_req_cmd),
    .o_l2_req_addr    (l2_req_addr),
    .o_l2_req_tag     (l2_req_tag),
    .o_l2_req_data    (l2_req_data),
    .o_l2_req_byte_en (l2_req_be),
    .i_l2_req_ready   (l2_req_ready),
    .i_l2_resp_valid  (l2_resp_valid),
    .i_l2_resp_tag    (l2_resp_tag),
    .i_l2_resp_data   (l2_resp_data),
    .o_l2_resp_ready  (l2_resp_ready)
  );

  function automatic int fpos(input int idx, input int f);
    return idx * N_FIELD + f;
  endfunction

  task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %s got 0x%0h expected 0x%0h", name, got, exp);
    end
  endtask

  task automatic report_error(input string msg);
    errors++;
    $display("ERROR: %s", msg);
  endtask

  task automatic load_sources(input int first, input int last);
    int s;
    for (int i = first; i < last; i++) begin
      s = int'(pat_mem[fpos(i, F_SRC)][1:0]);
      drv_q[s].push_back(i);
    end
  endtask

  task automatic wait_counts(input int n);
    int cycles;
    cycles = 0;
    while ((l2_req_count < n || resp_count < n) && cycles < TIMEOUT) begin
      @(negedge clk);
      cycles++;
    end
    if (l2_req_count < n || resp_count < n) begin
      report_error($sformatf("stalled for %0d cycles, %0d of %0d requests and %0d responses seen",
                             cycles, l2_req_count, n, resp_count));
      timed_out = 1'b1;
    end
  endtask

  task automatic finish_run();
    $display("errors=%0d checks=%0d", errors, checks);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  endtask

  // ---------------------------------------------------------------------
  // Requesters and L2 model, driven on the falling edge
  // ---------------------------------------------------------------------
  always @(negedge clk) begin
    int idx;
    int rnd;
    for (int s = 0; s < 3; s++) begin
      if (drv_q[s].size() > 0) begin
        idx          = drv_q[s][0];
        req_valid[s] = 1'b1;
        req_cmd[s]   = mem_cmd_t'(pat_mem[fpos(idx, F_CMD)][1:0]);
        req_addr[s]  = pat_mem[fpos(idx, F_ADDR)][PADDR_W-1:0];
        req_tag[s]   = pat_mem[fpos(idx, F_TAG)][REQ_TAG_W-1:0];
        req_data[s]  = pat_mem[fpos(idx, F_DATA)];
        req_be[s]    = pat_mem[fpos(idx, F_BE)][BE_W-1:0];
      end else begin
        req_valid[s] = 1'b0;
      end
      rnd           = $random(seed);
      resp_ready[s] = (rnd[1:0] != 2'd0);
    end
    rnd           = $random(seed);
    l2_req_ready  = (l2_mode == 2) || (l2_mode == 1 && rnd[0]);
    l2_resp_valid = (rtag_q.size() > 0);
    if (l2_resp_valid) begin
      l2_resp_tag  = rtag_q[0];
      l2_resp_data = rdata_q[0];
    end
  end

  // ---------------------------------------------------------------------
  // Monitors and scoreboards
  // ---------------------------------------------------------------------
  always @(posedge clk) begin
    int         idx;
    logic [1:0] src;
    if (!rst_n) begin
      check_val("o_l2_req_valid", 64'(l2_req_valid), 64'd0);
      for (int s = 0; s < 3; s++) begin
        check_val($sformatf("o_%s_resp_valid", src_name[s]), 64'(resp_valid[s]), 64'd0);
      end
    end else begin
      for (int s = 0; s < 3; s++) begin
        if (req_valid[s] && req_ready[s]) begin
          void'(drv_q[s].pop_front());
          acc_count++;
        end
      end
      // Response leaves before new requests queue up
      if (l2_resp_valid && l2_resp_ready) begin
        void'(rtag_q.pop_front());
        void'(rdata_q.pop_front());
      end
      if (l2_req_valid && l2_req_ready) begin
        l2_req_count++;
        src = l2_req_tag[L2_TAG_W-1 -: SRC_ID_W];
        if (src == 2'd3) begin
          report_error("L2 request carries the unused source code 3");
        end else if (exp_req_q[src].size() == 0) begin
          report_error($sformatf("extra L2 request from %s", src_name[src]));
        end else begin
          idx = exp_req_q[src].pop_front();
          check_val("o_l2_req_cmd", 64'(l2_req_cmd), pat_mem[fpos(idx, F_CMD)]);
          check_val("o_l2_req_addr", 64'(l2_req_addr), pat_mem[fpos(idx, F_ADDR)]);
          check_val("o_l2_req_data", l2_req_data, pat_mem[fpos(idx, F_DATA)]);
          check_val("o_l2_req_byte_en", 64'(l2_req_be), pat_mem[fpos(idx, F_BE)]);
          check_val("o_l2_req_tag", 64'(l2_req_tag),
                    64'({pat_mem[fpos(idx, F_SRC)][1:0], pat_mem[fpos(idx, F_TAG)][3:0]}));
          rtag_q.push_back(l2_req_tag);
          rdata_q.push_back(pat_mem[fpos(idx, F_RDATA)]);
          if (in_burst) begin
            // Round robin moves to the source after the winner
            if (burst_seen > 0) begin
              check_val("burst source", 64'(src),
                        64'((burst_prev == 2'd2) ? 2'd0 : burst_prev + 2'd1));
            end
            burst_prev = src;
            burst_seen++;
          end
        end
      end
      if ($countones({resp_valid[2], resp_valid[1], resp_valid[0]}) > 1) begin
        report_error("more than one requester sees a response at once");
      end
      for (int s = 0; s < 3; s++) begin
        if (hold_prev[s]) begin
          check_val($sformatf("o_%s_resp_valid", src_name[s]), 64'(resp_valid[s]), 64'd1);
          check_val($sformatf("o_%s_resp_tag", src_name[s]), 64'(resp_tag[s]),
                    64'(hold_tag[s]));
          check_val($sformatf("o_%s_resp_data", src_name[s]), resp_data[s], hold_data[s]);
        end
        if (resp_valid[s] && resp_ready[s]) begin
          resp_count++;
          if (exp_resp_q[s].size() == 0) begin
            report_error($sformatf("response to %s with nothing outstanding", src_name[s]));
          end else begin
            idx = exp_resp_q[s].pop_front();
            check_val($sformatf("o_%s_resp_tag", src_name[s]), 64'(resp_tag[s]),
                      pat_mem[fpos(idx, F_TAG)]);
            check_val($sformatf("o_%s_resp_data", src_name[s]), resp_data[s],
                      pat_mem[fpos(idx, F_RDATA)]);
          end
        end
        hold_prev[s] = resp_valid[s] && !resp_ready[s];
        hold_tag[s]  = resp_tag[s];
        hold_data[s] = resp_data[s];
      end
    end
  end

  initial begin
    int cycles;
    int s;
    errors       = 0;
    checks       = 0;
    acc_count    = 0;
    l2_req_count = 0;
    resp_count   = 0;
    burst_seen   = 0;
    burst_prev   = 2'd0;
    in_burst     = 1'b0;
    l2_mode      = 0;
    timed_out    = 1'b0;
    src_name     = '{"ic", "l1d", "ptw"};
    for (int i = 0; i < 3; i++) begin
      req_valid[i]  = 1'b0;
      req_cmd[i]    = CMD_RD;
      req_addr[i]   = '0;
      req_tag[i]    = '0;
      req_data[i]   = '0;
      req_be[i]     = '0;
      resp_ready[i] = 1'b0;
      hold_prev[i]  = 1'b0;
      hold_tag[i]   = '0;
      hold_data[i]  = '0;
    end
    l2_req_ready  = 1'b0;
    l2_resp_valid = 1'b0;
    l2_resp_tag   = '0;
    l2_resp_data  = '0;

    $readmemh("l2_patterns.txt", pat_mem);
    for (int i = 0; i < N_PAT; i++) begin
      s = int'(pat_mem[fpos(i, F_SRC)][1:0]);
      exp_req_q[s].push_back(i);
      exp_resp_q[s].push_back(i);
    end

    cycles = 0;
    while (rst_n !== 1'b1 && cycles < 20) begin
      @(posedge clk);
      cycles++;
    end
    if (rst_n !== 1'b1) begin
      report_error("reset was never released");
      timed_out = 1'b1;
    end

    // Idle right after reset
    for (int i = 0; i < 2; i++) begin
      @(posedge clk);
      check_val("o_l2_req_valid", 64'(l2_req_valid), 64'd0);
      check_val("o_*_resp_valid", 64'({resp_valid[2], resp_valid[1], resp_valid[0]}), 64'd0);
    end

    // L2 port stalled, pipeline fills and then blocks
    if (!timed_out) begin
      @(posedge clk);
      load_sources(0, N_RAND);
      for (int i = 0; i < 12; i++) begin
        @(posedge clk);
        if (i >= 8) begin
          check_val("o_*_req_ready", 64'({req_ready[2], req_ready[1], req_ready[0]}), 64'd0);
        end
      end
      @(negedge clk);
      if (acc_count > 3) begin
        report_error($sformatf("%0d requests accepted with L2 stalled, limit is 3", acc_count));
      end
      @(posedge clk);
      l2_mode = 1;
      wait_counts(N_RAND);
    end

    // All three sources at once with L2 always ready
    if (!timed_out) begin
      @(negedge clk);
      in_burst = 1'b1;
      @(posedge clk);
      l2_mode = 2;
      load_sources(N_RAND, N_PAT);
      wait_counts(N_PAT);
      check_val("burst requests", 64'(burst_seen), 64'(N_PAT - N_RAND));
    end

    for (int i = 0; i < 3; i++) begin
      if (exp_req_q[i].size() != 0 || exp_resp_q[i].size() != 0) begin
        report_error($sformatf("%s still has requests or responses outstanding", src_name[i]));
      end
    end
    finish_run();
  end

endmodule

// File: l2_patterns.txt
// src cmd addr data byte_en req_tag resp_data
// src 0 ic, 1 l1d, 2 ptw; cmd 0 read, 1 write
0 0 80001000 0000000000000000 ff 1 a5a5000000001001
1 1 80002008 deadbeefcafef00d 0f 2 00000000000000c2
2 0 8f000010 0000000000000000 ff 3 800000000000a013
1 0 80002010 0000000000000000 ff 4 1234567890abcdef
0 0 80001040 0000000000000000 ff 5 a5a5000000001045
1 1 80002018 0123456789abcdef f0 6 00000000000000c6
2 0 8f000018 0000000000000000 ff 7 800000000000a017
0 0 80001080 0000000000000000 ff 8 a5a5000000001088
1 1 80002020 ffffffff00000000 3c 9 00000000000000c9
0 0 800010c0 0000000000000000 ff a a5a50000000010ca
2 0 8f000020 0000000000000000 ff b 800000000000a01b
1 0 80002028 0000000000000000 ff c fedcba0987654321
// Burst phase, three requests per source
0 0 80003000 0000000000000000 ff 0 b0b0000000003000
1 1 80004000 5555aaaa5555aaaa ff 1 00000000000000d1
2 0 8f001000 0000000000000000 ff 2 800000000000b002
0 0 80003040 0000000000000000 ff 3 b0b0000000003043
1 0 80004008 0000000000000000 ff 4 7777666655554444
2 0 8f001008 0000000000000000 ff 5 800000000000b005
0 0 80003080 0000000000000000 ff 6 b0b0000000003086
1 1 80004010 00000000ffffffff 0f 7 00000000000000d7
2 0 8f001010 0000000000000000 ff 8 800000000000b008

// File: list.f
l2_pkg.sv
l2_req_arbiter.sv
l2_req_slice.sv
l2_resp_router.sv
tile_l2_wrapper.sv
tb_clk_gen.sv
tb_tile_l2.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_tile_l2
FLIST     ?= list.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing --assert --timescale 1ns/1ps
PASS_MSG  ?= sim passed

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FLIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
